// File: logic/pong_defines.svh
`ifndef PONG_DEFINES_SVH
`define PONG_DEFINES_SVH

// raster geometry, in pixel clocks and lines
`define H_TOTAL         1040
`define H_SYNC_START    919
`define H_SYNC_END      1039
`define V_TOTAL         666
`define V_SYNC_START    659
`define V_SYNC_END      665

// play field
`define FIELD_TOP       23
`define FIELD_BOTTOM    623
`define FIELD_LEFT      104
`define FIELD_RIGHT     904

// object sizes and rows
`define PAD_HALF_W      50
`define PAD_HALF_H      10
`define CATCH_HALF      60
`define BALL_R          10
`define BALL_R2         100
`define PLAYER_ROW      (`FIELD_TOP + 500)
`define CPU_ROW         (`FIELD_TOP + 100)

// rows where the ball turns or gets judged
`define TOP_LIMIT       (`FIELD_TOP + 102)
`define BOTTOM_LIMIT    (`FIELD_BOTTOM - 102)

`define BALL_START_ROW  (`FIELD_TOP + 120)
`define BALL_START_COL  (`FIELD_LEFT + 400)
`define PAD_START_COL   (`FIELD_LEFT + 400)

`define PAD_STEP        5
`define BOOST_STEP      5
`define SCORE_MAX       99

// {r, g, b}
`define COLOR_BLACK     3'b000
`define COLOR_RED       3'b100
`define COLOR_GREEN     3'b010
`define COLOR_BLUE      3'b001
`define COLOR_YELLOW    3'b110

`endif

// File: logic/pong_pkg.sv
package pong_pkg;

	// screen coordinate, wide enough for the full raster
	typedef logic [10:0] coord_t;

	// catch count, saturates below 128
	typedef logic [6:0] score_t;

	typedef struct packed
	{
		logic r;
		logic g;
		logic b;
	} rgb_t;

	typedef enum logic [1:0]
	{
		UP_RIGHT   = 2'd0,
		UP_LEFT    = 2'd1,
		DOWN_LEFT  = 2'd2,
		DOWN_RIGHT = 2'd3
	} dir_t;

	// what one frame needs to draw the game
	typedef struct packed
	{
		coord_t ball_row;
		coord_t ball_col;
		coord_t pad_col;
		logic   boost;
	} snapshot_t;

endpackage

// File: logic/raster_timing.sv
`timescale 1ns/1ps
`include "pong_defines.svh"

module raster_timing
	import pong_pkg::*;
(
	input  logic   clk,
	input  logic   rst,
	output coord_t col,
	output coord_t row,
	output logic   hsync,
	output logic   vsync,
	output logic   frame_start
);

	localparam coord_t H_LAST    = coord_t'(`H_TOTAL - 1);
	localparam coord_t V_LAST    = coord_t'(`V_TOTAL - 1);
	localparam coord_t HS_START  = coord_t'(`H_SYNC_START);
	localparam coord_t HS_END    = coord_t'(`H_SYNC_END);
	localparam coord_t VS_START  = coord_t'(`V_SYNC_START);
	localparam coord_t VS_END    = coord_t'(`V_SYNC_END);
	localparam coord_t BLANK_ROW = coord_t'(`FIELD_BOTTOM + 1);

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			col <= '0;
			row <= '0;
		end
		else if (col == H_LAST)
		begin
			col <= '0;
			if (row == V_LAST)
				row <= '0;
			else
				row <= row + 11'd1;
		end
		else
			col <= col + 11'd1;
	end

	// sync pulses are active low
	assign hsync = !((col >= HS_START) && (col < HS_END));
	assign vsync = !((row >= VS_START) && (row < VS_END));

	// first line below the field, safe point for the snapshot swap
	assign frame_start = (row == BLANK_ROW) && (col == '0);

endmodule

// File: logic/game_core.sv
`timescale 1ns/1ps
`include "pong_defines.svh"

module game_core
	import pong_pkg::*;
#(
	parameter int unsigned step_period = 500000
)
(
	input  logic      clk,
	input  logic      rst,
	input  logic      left,
	input  logic      right,
	input  logic      boost,
	input  logic      snap_ack,
	output logic      snap_req,
	output snapshot_t snap_data,
	output score_t    score
);

	localparam int unsigned FAST_LIMIT = (step_period / 100 < 7) ? 7 : step_period / 100;
	localparam int unsigned LIMIT_TABLE [11] = '{
		step_period,
		step_period * 9 / 10,
		step_period * 8 / 10,
		step_period * 7 / 10,
		step_period * 6 / 10,
		step_period * 5 / 10,
		step_period * 4 / 10,
		step_period * 3 / 10,
		step_period * 2 / 10,
		step_period * 1 / 10,
		FAST_LIMIT
	};

	localparam coord_t PAD_MIN    = coord_t'(`FIELD_LEFT + `PAD_HALF_W);
	localparam coord_t PAD_MAX    = coord_t'(`FIELD_RIGHT - `PAD_HALF_W);
	localparam coord_t TOP_HIT    = coord_t'(`TOP_LIMIT + `BALL_R);
	localparam coord_t LEFT_HIT   = coord_t'(`FIELD_LEFT + `BALL_R);
	localparam coord_t RIGHT_HIT  = coord_t'(`FIELD_RIGHT - `BALL_R);
	localparam coord_t BOTTOM_HIT = coord_t'(`BOTTOM_LIMIT - `BALL_R);
	localparam coord_t CATCH      = coord_t'(`CATCH_HALF);

	logic [31:0] step_cnt;
	logic [31:0] limit;
	logic [3:0]  tier;
	logic        step_tick;

	coord_t ball_row, ball_col, pad_col;
	dir_t   dir;
	coord_t row_next, col_next, pad_next, move_step;
	dir_t   dir_next;
	score_t score_next;
	logic   miss, up_next, right_next;
	logic   offer, launch;

	// faster ticks every three catches up to tier 10
	assign tier  = (score >= 7'd30) ? 4'd10 : 4'(score / 7'd3);
	assign limit = LIMIT_TABLE[tier];
	assign step_tick = (step_cnt >= limit);

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
			step_cnt <= '0;
		else if (step_tick)
			step_cnt <= '0;
		else
			step_cnt <= step_cnt + 32'd1;
	end

	always_comb
	begin
		pad_next = pad_col;
		if (left)
		begin
			if (pad_col > PAD_MIN)
				pad_next = pad_col - coord_t'(`PAD_STEP);
		end
		else if (right)
		begin
			if (pad_col < PAD_MAX)
				pad_next = pad_col + coord_t'(`PAD_STEP);
		end

		dir_next   = dir;
		miss       = 1'b0;
		score_next = score;
		if (ball_row <= TOP_HIT)
		begin
			case (dir)
				UP_RIGHT: dir_next = DOWN_RIGHT;
				UP_LEFT:  dir_next = DOWN_LEFT;
				default:  dir_next = dir;
			endcase
		end
		else if (ball_col <= LEFT_HIT)
		begin
			case (dir)
				UP_LEFT:   dir_next = UP_RIGHT;
				DOWN_LEFT: dir_next = DOWN_RIGHT;
				default:   dir_next = dir;
			endcase
		end
		else if (ball_col >= RIGHT_HIT)
		begin
			case (dir)
				UP_RIGHT:   dir_next = UP_LEFT;
				DOWN_RIGHT: dir_next = DOWN_LEFT;
				default:    dir_next = dir;
			endcase
		end
		else if (ball_row >= BOTTOM_HIT)
		begin
			if ((ball_col + CATCH >= pad_col) && (ball_col <= pad_col + CATCH))
			begin
				case (dir)
					DOWN_RIGHT: dir_next = UP_RIGHT;
					DOWN_LEFT:  dir_next = UP_LEFT;
					default:    dir_next = dir;
				endcase
				if (score != score_t'(`SCORE_MAX))
					score_next = score + 7'd1;
			end
			else
			begin
				miss       = 1'b1;
				score_next = '0;
			end
		end

		up_next    = (dir_next == UP_RIGHT) || (dir_next == UP_LEFT);
		right_next = (dir_next == UP_RIGHT) || (dir_next == DOWN_RIGHT);
		move_step  = (up_next && boost) ? coord_t'(`BOOST_STEP) : 11'd1;
		row_next   = up_next ? ball_row - move_step : ball_row + move_step;
		col_next   = right_next ? ball_col + move_step : ball_col - move_step;
		// a miss serves again from the start row in the same column
		if (miss)
		begin
			row_next = coord_t'(`BALL_START_ROW);
			col_next = ball_col;
		end
	end

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			ball_row <= coord_t'(`BALL_START_ROW);
			ball_col <= coord_t'(`BALL_START_COL);
			pad_col  <= coord_t'(`PAD_START_COL);
			dir      <= DOWN_RIGHT;
			score    <= '0;
		end
		else if (step_tick)
		begin
			ball_row <= row_next;
			ball_col <= col_next;
			pad_col  <= pad_next;
			dir      <= dir_next;
			score    <= score_next;
		end
	end

	// offer fresh state the cycle after a tick unless still busy
	assign launch = offer && !snap_req && !snap_ack;

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			offer    <= 1'b0;
			snap_req <= 1'b0;
		end
		else
		begin
			offer <= step_tick;
			if (launch)
				snap_req <= 1'b1;
			else if (snap_req && snap_ack)
				snap_req <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (launch)
		begin
			snap_data.ball_row <= ball_row;
			snap_data.ball_col <= ball_col;
			snap_data.pad_col  <= pad_col;
			snap_data.boost    <= boost && ((dir == UP_RIGHT) || (dir == UP_LEFT));
		end
	end

	// the handshake needs room between two ticks
	assert property (@(posedge clk) disable iff (rst)
		step_tick |=> !step_tick [*6]);

	// the buffer answers only a raised request
	assert property (@(posedge clk) disable iff (rst)
		$rose(snap_ack) |-> $past(snap_req));

endmodule

// File: logic/frame_state_buffer.sv
`timescale 1ns/1ps

module frame_state_buffer
	import pong_pkg::*;
#(
	parameter type payload_t = snapshot_t,
	parameter payload_t init_value = '0
)
(
	input  logic     clk,
	input  logic     rst,
	input  logic     req,
	input  payload_t data,
	input  logic     frame_start,
	output logic     ack,
	output payload_t shown
);

	payload_t pending;

	// four-phase receiver side
	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
			ack <= 1'b0;
		else if (req && !ack)
			ack <= 1'b1;
		else if (!req && ack)
			ack <= 1'b0;
	end

	// pending takes each new offer while the display swaps only in blanking
	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			pending <= init_value;
			shown   <= init_value;
		end
		else
		begin
			if (req && !ack)
				pending <= data;
			if (frame_start)
				shown <= pending;
		end
	end

	// the sender holds req until it has seen ack
	assert property (@(posedge clk) disable iff (rst)
		$fell(req) |-> $past(ack));

endmodule

// File: logic/pixel_renderer.sv
`timescale 1ns/1ps
`include "pong_defines.svh"

module pixel_renderer
	import pong_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  coord_t    col,
	input  coord_t    row,
	input  snapshot_t shown,
	input  rgb_t      bg,
	input  logic      hsync_in,
	input  logic      vsync_in,
	output rgb_t      rgb,
	output logic      hsync,
	output logic      vsync
);

	localparam coord_t HALF_W     = coord_t'(`PAD_HALF_W);
	localparam coord_t HALF_H     = coord_t'(`PAD_HALF_H);
	localparam coord_t PLAYER_ROW = coord_t'(`PLAYER_ROW);
	localparam coord_t CPU_ROW    = coord_t'(`CPU_ROW);
	localparam coord_t F_TOP      = coord_t'(`FIELD_TOP);
	localparam coord_t F_BOTTOM   = coord_t'(`FIELD_BOTTOM);
	localparam coord_t F_LEFT     = coord_t'(`FIELD_LEFT);
	localparam coord_t F_RIGHT    = coord_t'(`FIELD_RIGHT);

	logic signed [11:0] d_row, d_col;
	logic [23:0]        sq_row, sq_col;
	logic [24:0]        dist2;
	logic               in_field;
	rgb_t               colour;

	function automatic logic in_pad(coord_t c, coord_t r, coord_t cc, coord_t rc);
		return (c + HALF_W >= cc) && (c <= cc + HALF_W)
			&& (r + HALF_H >= rc) && (r <= rc + HALF_H);
	endfunction

	// squared distance to the ball centre
	assign d_row  = $signed({1'b0, row}) - $signed({1'b0, shown.ball_row});
	assign d_col  = $signed({1'b0, col}) - $signed({1'b0, shown.ball_col});
	assign sq_row = 24'(d_row) * 24'(d_row);
	assign sq_col = 24'(d_col) * 24'(d_col);
	assign dist2  = {1'b0, sq_row} + {1'b0, sq_col};

	assign in_field = (col >= F_LEFT) && (col <= F_RIGHT) && (row >= F_TOP) && (row <= F_BOTTOM);

	always_comb
	begin
		if (dist2 < 25'(`BALL_R2))
			colour = shown.boost ? rgb_t'(`COLOR_YELLOW) : rgb_t'(`COLOR_RED);
		else if (in_pad(col, row, shown.pad_col, PLAYER_ROW))
			colour = rgb_t'(`COLOR_GREEN);
		// computer paddle tracks the ball column
		else if (in_pad(col, row, shown.ball_col, CPU_ROW))
			colour = rgb_t'(`COLOR_BLUE);
		else if (in_field)
			colour = bg;
		else
			colour = rgb_t'(`COLOR_BLACK);
	end

	// one register stage, syncs delayed alongside
	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			rgb   <= rgb_t'(`COLOR_BLACK);
			hsync <= 1'b1;
			vsync <= 1'b1;
		end
		else
		begin
			rgb   <= colour;
			hsync <= hsync_in;
			vsync <= vsync_in;
		end
	end

endmodule

// File: logic/pong_top.sv
`timescale 1ns/1ps
`include "pong_defines.svh"

module pong_top
	import pong_pkg::*;
#(
	parameter int unsigned step_period = 500000
)
(
	input  logic   clk,
	input  logic   rst,
	input  logic   left,
	input  logic   right,
	input  logic   boost,
	input  rgb_t   bg,
	output rgb_t   rgb,
	output logic   hsync,
	output logic   vsync,
	output score_t score
);

	// what the display shows until the first swap
	localparam snapshot_t START_SNAP = '{
		ball_row: coord_t'(`BALL_START_ROW),
		ball_col: coord_t'(`BALL_START_COL),
		pad_col:  coord_t'(`PAD_START_COL),
		boost:    1'b0
	};

	coord_t    col, row;
	logic      raw_hsync, raw_vsync, frame_start;
	logic      snap_req, snap_ack;
	snapshot_t snap_data, shown;

	raster_timing raster_timing_i (
		.clk         (clk),
		.rst         (rst),
		.col         (col),
		.row         (row),
		.hsync       (raw_hsync),
		.vsync       (raw_vsync),
		.frame_start (frame_start)
	);

	game_core #(.step_period(step_period)) game_core_i (
		.clk       (clk),
		.rst       (rst),
		.left      (left),
		.right     (right),
		.boost     (boost),
		.snap_ack  (snap_ack),
		.snap_req  (snap_req),
		.snap_data (snap_data),
		.score     (score)
	);

	frame_state_buffer #(
		.payload_t  (snapshot_t),
		.init_value (START_SNAP)
	) frame_state_buffer_i (
		.clk         (clk),
		.rst         (rst),
		.req         (snap_req),
		.data        (snap_data),
		.frame_start (frame_start),
		.ack         (snap_ack),
		.shown       (shown)
	);

	pixel_renderer pixel_renderer_i (
		.clk      (clk),
		.rst      (rst),
		.col      (col),
		.row      (row),
		.shown    (shown),
		.bg       (bg),
		.hsync_in (raw_hsync),
		.vsync_in (raw_vsync),
		.rgb      (rgb),
		.hsync    (hsync),
		.vsync    (vsync)
	);

endmodule

// File: sim/pong_tb_model.svh
`ifndef PONG_TB_MODEL_SVH
`define PONG_TB_MODEL_SVH

// game state as it stands after one tick
typedef struct packed
{
	coord_t ball_row;
	coord_t ball_col;
	coord_t pad_col;
	dir_t   dir;
	score_t score;
} game_state_t;

function automatic bit heads_up(dir_t d);
	return (d == UP_RIGHT) || (d == UP_LEFT);
endfunction

function automatic dir_t compose_dir(bit up, bit rt);
	if (up)
		return rt ? UP_RIGHT : UP_LEFT;
	return rt ? DOWN_RIGHT : DOWN_LEFT;
endfunction

function automatic game_state_t start_state();
	game_state_t s;
	s.ball_row = coord_t'(`BALL_START_ROW);
	s.ball_col = coord_t'(`BALL_START_COL);
	s.pad_col  = coord_t'(`PAD_START_COL);
	s.dir      = DOWN_RIGHT;
	s.score    = '0;
	return s;
endfunction

function automatic snapshot_t show_state(game_state_t s, logic b);
	snapshot_t v;
	v.ball_row = s.ball_row;
	v.ball_col = s.ball_col;
	v.pad_col  = s.pad_col;
	v.boost    = b && heads_up(s.dir);
	return v;
endfunction

// cycles between ticks minus one for a score tier
function automatic int tick_limit(score_t s, int period);
	int tier;
	tier = int'(s) / 3;
	if (tier >= 10)
		return (period / 100 < 7) ? 7 : period / 100;
	return period * (10 - tier) / 10;
endfunction

function automatic game_state_t play_tick(game_state_t s, logic l, logic r, logic b);
	game_state_t n;
	int row;
	int col;
	int pad;
	int step;
	bit up;
	bit rt;
	bit miss;
	n = s;
	row = int'(s.ball_row);
	col = int'(s.ball_col);
	pad = int'(s.pad_col);
	up = heads_up(s.dir);
	rt = (s.dir == UP_RIGHT) || (s.dir == DOWN_RIGHT);
	miss = 1'b0;
	// left wins when both are held
	if (l)
	begin
		if (pad - `PAD_HALF_W > `FIELD_LEFT)
			n.pad_col = coord_t'(pad - `PAD_STEP);
	end
	else if (r)
	begin
		if (pad + `PAD_HALF_W < `FIELD_RIGHT)
			n.pad_col = coord_t'(pad + `PAD_STEP);
	end
	if (row - `BALL_R <= `TOP_LIMIT)
		up = 1'b0;
	else if (col - `BALL_R <= `FIELD_LEFT)
		rt = 1'b1;
	else if (col + `BALL_R >= `FIELD_RIGHT)
		rt = 1'b0;
	else if (row + `BALL_R >= `BOTTOM_LIMIT)
	begin
		if ((col - pad <= `CATCH_HALF) && (pad - col <= `CATCH_HALF))
		begin
			up = 1'b1;
			if (int'(s.score) < `SCORE_MAX)
				n.score = s.score + 7'd1;
		end
		else
		begin
			miss = 1'b1;
			n.score = '0;
		end
	end
	n.dir = compose_dir(up, rt);
	step = (up && b) ? `BOOST_STEP : 1;
	// a miss keeps column and heading
	if (miss)
		n.ball_row = coord_t'(`BALL_START_ROW);
	else
	begin
		n.ball_row = coord_t'(up ? row - step : row + step);
		n.ball_col = coord_t'(rt ? col + step : col - step);
	end
	return n;
endfunction

function automatic bit inside_box(int c, int r, int cc, int rc);
	return (c - cc <= `PAD_HALF_W) && (cc - c <= `PAD_HALF_W)
		&& (r - rc <= `PAD_HALF_H) && (rc - r <= `PAD_HALF_H);
endfunction

function automatic rgb_t expected_pixel(int c, int r, snapshot_t v, rgb_t bg);
	int dr;
	int dc;
	dr = r - int'(v.ball_row);
	dc = c - int'(v.ball_col);
	if (dr * dr + dc * dc < `BALL_R2)
		return v.boost ? rgb_t'(`COLOR_YELLOW) : rgb_t'(`COLOR_RED);
	if (inside_box(c, r, int'(v.pad_col), `PLAYER_ROW))
		return rgb_t'(`COLOR_GREEN);
	if (inside_box(c, r, int'(v.ball_col), `CPU_ROW))
		return rgb_t'(`COLOR_BLUE);
	if ((c >= `FIELD_LEFT) && (c <= `FIELD_RIGHT) && (r >= `FIELD_TOP) && (r <= `FIELD_BOTTOM))
		return bg;
	return rgb_t'(`COLOR_BLACK);
endfunction

// low from first to last, both included
function automatic logic sync_level(int pos, int first, int last);
	return (pos < first) || (pos > last);
endfunction

`endif

// File: sim/pong_tb.sv
`timescale 1ns/1ps
`include "pong_defines.svh"

module pong_tb
	import pong_pkg::*;
();

	localparam int STEP_PERIOD  = 200;
	localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
	localparam int CYCLE_LIMIT  = 6 * FRAME_CYCLES + 20000;

	logic   clk;
	logic   rst;
	logic   left;
	logic   right;
	logic   boost;
	rgb_t   bg;
	rgb_t   rgb;
	logic   hsync;
	logic   vsync;
	score_t score;

	pong_top #(.step_period(STEP_PERIOD)) pong_top_i (
		.clk   (clk),
		.rst   (rst),
		.left  (left),
		.right (right),
		.boost (boost),
		.bg    (bg),
		.rgb   (rgb),
		.hsync (hsync),
		.vsync (vsync),
		.score (score)
	);

	`include "pong_tb_model.svh"

	game_state_t m_state;
	snapshot_t   m_offer, m_pending, m_shown;
	int          m_cnt, m_col, m_row, hs_age;
	bit          tick_seen, launch_seen;
	rgb_t        exp_rgb;
	logic        exp_hsync, exp_vsync;
	int          cycle_count = 0;
	int          seed;

	always #50 clk = !clk;

	task automatic abort_run(string what);
		$display("%s", what);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic check_rgb(rgb_t got, rgb_t want, string name);
		if (got !== want)
			abort_run($sformatf("Error at %0t: %s is %b, expected %b", $time, name, got, want));
	endtask

	task automatic check_score(score_t got, score_t want, string name);
		if (got !== want)
			abort_run($sformatf("Error at %0t: %s is %0d, expected %0d", $time, name, got, want));
	endtask

	task automatic check_sync(logic got, logic want, string name);
		if (got !== want)
			abort_run($sformatf("Error at %0t: %s is %b, expected %b", $time, name, got, want));
	endtask

	task automatic wait_ticks(int n);
		repeat (n * (STEP_PERIOD + 1)) @(posedge clk);
	endtask

	task automatic steer_paddle(int target);
		int pad;
		pad = int'(m_state.pad_col);
		left  <= (pad > target + 2);
		right <= (pad < target - 2);
	endtask

	// lockstep reference of raster, ticks, snapshot handshake and frame swap
	always @(posedge clk, posedge rst)
	begin
		bit tick_now;
		bit launch_now;
		if (rst)
		begin
			m_state     <= start_state();
			m_offer     <= show_state(start_state(), 1'b0);
			m_pending   <= show_state(start_state(), 1'b0);
			m_shown     <= show_state(start_state(), 1'b0);
			m_cnt       <= 0;
			m_col       <= 0;
			m_row       <= 0;
			hs_age      <= 4;
			tick_seen   <= 1'b0;
			launch_seen <= 1'b0;
			exp_rgb     <= rgb_t'(`COLOR_BLACK);
			exp_hsync   <= 1'b1;
			exp_vsync   <= 1'b1;
		end
		else
		begin
			exp_rgb   <= expected_pixel(m_col, m_row, m_shown, bg);
			exp_hsync <= sync_level(m_col, `H_SYNC_START, `H_SYNC_END - 1);
			exp_vsync <= sync_level(m_row, `V_SYNC_START, `V_SYNC_END - 1);
			// swap on the first line below the field
			if ((m_row == `FIELD_BOTTOM + 1) && (m_col == 0))
				m_shown <= m_pending;
			if (m_col == `H_TOTAL - 1)
			begin
				m_col <= 0;
				m_row <= (m_row == `V_TOTAL - 1) ? 0 : m_row + 1;
			end
			else
				m_col <= m_col + 1;
			tick_now = (m_cnt >= tick_limit(m_state.score, STEP_PERIOD));
			if (tick_now)
			begin
				m_state <= play_tick(m_state, left, right, boost);
				m_cnt   <= 0;
			end
			else
				m_cnt <= m_cnt + 1;
			tick_seen <= tick_now;
			// offer after a tick only once the last four-phase cycle is over
			launch_now = tick_seen && (hs_age >= 4);
			if (launch_now)
			begin
				m_offer <= show_state(m_state, boost);
				hs_age  <= 1;
			end
			else if (hs_age < 4)
				hs_age <= hs_age + 1;
			launch_seen <= launch_now;
			if (launch_seen)
				m_pending <= m_offer;
		end
	end

	// outputs are settled mid cycle
	always @(negedge clk)
	begin
		if (!rst)
		begin
			check_rgb(rgb, exp_rgb, "rgb");
			check_sync(hsync, exp_hsync, "hsync");
			check_sync(vsync, exp_vsync, "vsync");
			check_score(score, m_state.score, "score");
		end
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
			abort_run($sformatf("timeout, the run did not end within %0d cycles", CYCLE_LIMIT));
	end

	initial
	begin
		int pick;
		int hold;
		seed  = 32'h41b3_0a9b;
		clk   = 1'b0;
		rst   = 1'b1;
		left  = 1'b0;
		right = 1'b0;
		boost = 1'b0;
		bg    = rgb_t'(3'b011);
		repeat (4) @(posedge clk);
		rst <= 1'b0;

		// run the paddle into both walls
		left <= 1'b1;
		wait_ticks(80);
		left  <= 1'b0;
		right <= 1'b1;
		wait_ticks(150);

		repeat (4)
		begin
			pick = $random(seed);
			left  <= pick[0];
			right <= pick[1];
			bg    <= rgb_t'(pick[4:2]);
			wait_ticks(8 + ((pick >> 8) & 31));
		end

		// follow the ball until tier 2 while boost and bg change now and then
		hold = 0;
		while (int'(m_state.score) < 6)
		begin
			@(posedge clk);
			steer_paddle(int'(m_state.ball_col));
			if (hold == 0)
			begin
				pick = $random(seed);
				boost <= pick[0];
				bg    <= rgb_t'(pick[3:1]);
				hold = 3000 + ((pick >> 4) & 16383);
			end
			else
				hold = hold - 1;
		end

		// park on the far side and let the ball drop
		boost <= 1'b0;
		if (int'(m_state.ball_col) < `BALL_START_COL)
		begin
			left  <= 1'b0;
			right <= 1'b1;
		end
		else
		begin
			left  <= 1'b1;
			right <= 1'b0;
		end
		while (m_state.score != '0)
			@(posedge clk);
		@(negedge clk);
		check_score(score, score_t'(0), "score");

		repeat (FRAME_CYCLES) @(posedge clk);
		$display("NO ERRORS");
		$finish;
	end

endmodule

// File: src.f
+incdir+logic
+incdir+sim
logic/pong_pkg.sv
logic/raster_timing.sv
logic/game_core.sv
logic/frame_state_buffer.sv
logic/pixel_renderer.sv
logic/pong_top.sv
sim/pong_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the pong testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f src.f --top-module pong_tb -o pong_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/pong_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation failed with status $status"
	exit "$status"
fi

echo "simulation finished cleanly"
exit 0
